/* hw/dm_pkg.sv */
`default_nettype none

package dm_pkg;

  // -------------------------------------------------------------------------
  // sizes and counts
  // -------------------------------------------------------------------------
  localparam int unsigned NrHarts       = 4;
  localparam int unsigned HartSelLen    = 2;
  localparam int unsigned DataCount     = 2;
  localparam int unsigned ProgBufSize   = 8;
  localparam int unsigned DataIdxLen    = 1;
  localparam int unsigned ProgBufIdxLen = 3;
  localparam int unsigned RespFifoDepth = 2;

  typedef logic [31:0]        word_t;
  typedef logic [6:0]         dmi_addr_t;
  typedef logic [NrHarts-1:0] hart_vec_t;
  typedef logic [9:0]         hartsel_t;

  typedef enum logic [1:0] {
    DtmNop   = 2'd0,
    DtmRead  = 2'd1,
    DtmWrite = 2'd2
  } dtm_op_e;

  typedef enum logic [2:0] {
    CmdErrNone         = 3'd0,
    CmdErrBusy         = 3'd1,
    CmdErrNotSupported = 3'd2,
    CmdErrException    = 3'd3,
    CmdErrHaltResume   = 3'd4,
    CmdErrBus          = 3'd5,
    CmdErrOther        = 3'd7
  } cmderr_e;

  // -------------------------------------------------------------------------
  // register map
  // -------------------------------------------------------------------------
  localparam dmi_addr_t AddrData0        = 7'h04;
  localparam dmi_addr_t AddrDmControl    = 7'h10;
  localparam dmi_addr_t AddrDmStatus     = 7'h11;
  localparam dmi_addr_t AddrAbstractCs   = 7'h16;
  localparam dmi_addr_t AddrCommand      = 7'h17;
  localparam dmi_addr_t AddrAbstractAuto = 7'h18;
  localparam dmi_addr_t AddrProgBuf0     = 7'h20;
  localparam dmi_addr_t AddrHaltSum0     = 7'h40;

  // dmcontrol fields
  localparam int unsigned HaltReqBit      = 31;
  localparam int unsigned ResumeReqBit    = 30;
  localparam int unsigned AckHaveResetBit = 28;
  localparam int unsigned HartSelLsb      = 16;
  localparam int unsigned NdmResetBit     = 1;
  localparam int unsigned DmActiveBit     = 0;

  // dmstatus fields
  localparam int unsigned StatusAllHaveReset   = 19;
  localparam int unsigned StatusAnyHaveReset   = 18;
  localparam int unsigned StatusAllResumeAck   = 17;
  localparam int unsigned StatusAnyResumeAck   = 16;
  localparam int unsigned StatusAllNonExistent = 15;
  localparam int unsigned StatusAnyNonExistent = 14;
  localparam int unsigned StatusAllUnavail     = 13;
  localparam int unsigned StatusAnyUnavail     = 12;
  localparam int unsigned StatusAllRunning     = 11;
  localparam int unsigned StatusAnyRunning     = 10;
  localparam int unsigned StatusAllHalted      = 9;
  localparam int unsigned StatusAnyHalted      = 8;
  localparam int unsigned StatusAuthenticated  = 7;
  localparam int unsigned DbgVersion           = 2;

  // abstractcs and abstractauto fields
  localparam int unsigned AbsProgBufSizeLsb = 24;
  localparam int unsigned AbsBusyBit        = 12;
  localparam int unsigned AbsCmdErrLsb      = 8;
  localparam int unsigned AbsDataCountLsb   = 0;
  localparam int unsigned AutoProgBufLsb    = 16;

endpackage

`default_nettype wire

/* hw/dm_reg_if.sv */
`timescale 1ns/1ps
`default_nettype none

// one accepted register access, fanned out to a register block
interface dm_reg_if;
  import dm_pkg::*;

  logic      acc;
  logic      we;
  dmi_addr_t addr;
  word_t     wdata;
  word_t     rdata;

  modport front (
    output acc, we, addr, wdata,
    input  rdata
  );

  modport regs (
    input  acc, we, addr, wdata,
    output rdata
  );

endinterface

`default_nettype wire

/* hw/dm_resp_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module dm_resp_fifo #(
  parameter int unsigned Depth = 2
) (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          push_i,
  input  dm_pkg::word_t data_i,
  input  logic          pop_i,
  output dm_pkg::word_t data_o,
  output logic          full_o,
  output logic          empty_o
);
  import dm_pkg::*;

  localparam int unsigned PtrLen = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntLen = $clog2(Depth + 1);

  word_t             mem_q [Depth];
  logic [PtrLen-1:0] rd_ptr_q, wr_ptr_q;
  logic [CntLen-1:0] cnt_q;
  logic              do_push, do_pop;

  assign full_o  = (cnt_q == CntLen'(Depth));
  assign empty_o = (cnt_q == '0);
  assign data_o  = mem_q[rd_ptr_q];
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PtrLen'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrLen'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // count only moves when exactly one side is active
      if (do_push && !do_pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (do_pop && !do_push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // the DMI front must respect the flags
  assert property (@(posedge clk_i) disable iff (!rst_ni) full_o |-> !push_i);
  assert property (@(posedge clk_i) disable iff (!rst_ni) empty_o |-> !pop_i);

endmodule

`default_nettype wire

/* hw/dm_dmi_front.sv */
`timescale 1ns/1ps
`default_nettype none

module dm_dmi_front (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              dmi_req_valid_i,
  output logic              dmi_req_ready_o,
  input  dm_pkg::dtm_op_e   dmi_req_op_i,
  input  dm_pkg::dmi_addr_t dmi_req_addr_i,
  input  dm_pkg::word_t     dmi_req_data_i,
  output logic              dmi_resp_valid_o,
  input  logic              dmi_resp_ready_i,
  output dm_pkg::word_t     dmi_resp_data_o,
  dm_reg_if.front           hart_bus,
  dm_reg_if.front           abs_bus
);
  import dm_pkg::*;

  logic  fifo_full, fifo_empty;
  logic  req_fire, req_acc;
  word_t resp_word;

  assign dmi_req_ready_o  = ~fifo_full;
  assign dmi_resp_valid_o = ~fifo_empty;
  assign req_fire         = dmi_req_valid_i & dmi_req_ready_o;
  // nop and reserved ops are answered but touch no register
  assign req_acc = req_fire && (dmi_req_op_i inside {DtmRead, DtmWrite});

  // broadcast to both register blocks
  assign hart_bus.acc   = req_acc;
  assign hart_bus.we    = (dmi_req_op_i == DtmWrite);
  assign hart_bus.addr  = dmi_req_addr_i;
  assign hart_bus.wdata = dmi_req_data_i;
  assign abs_bus.acc    = req_acc;
  assign abs_bus.we     = (dmi_req_op_i == DtmWrite);
  assign abs_bus.addr   = dmi_req_addr_i;
  assign abs_bus.wdata  = dmi_req_data_i;

  // blocks return zero outside their own addresses
  assign resp_word = req_acc ? (hart_bus.rdata | abs_bus.rdata) : '0;

  dm_resp_fifo #(
    .Depth   (RespFifoDepth)
  ) u_resp_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (req_fire),
    .data_i  (resp_word),
    .pop_i   (dmi_resp_ready_i & ~fifo_empty),
    .data_o  (dmi_resp_data_o),
    .full_o  (fifo_full),
    .empty_o (fifo_empty)
  );

endmodule

`default_nettype wire

/* hw/dm_hart_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module dm_hart_ctrl (
  input  logic              clk_i,
  input  logic              rst_ni,
  dm_reg_if.regs            bus,
  input  dm_pkg::hart_vec_t halted_i,
  input  dm_pkg::hart_vec_t unavailable_i,
  input  dm_pkg::hart_vec_t resumeack_i,
  output dm_pkg::hart_vec_t haltreq_o,
  output dm_pkg::hart_vec_t resumereq_o,
  output logic              clear_resumeack_o,
  output logic              ndmreset_o,
  output logic              dmactive_o
);
  import dm_pkg::*;

  logic                  dmactive_q, ndmreset_q, haltreq_q, resumereq_q;
  hartsel_t              hartsel_q;
  hart_vec_t             havereset_q;
  logic                  ctrl_wr, wr_active;
  hartsel_t              wr_hartsel;
  logic                  sel_valid, wr_sel_valid;
  logic [HartSelLen-1:0] sel_idx, wr_sel_idx;
  word_t                 dmcontrol, dmstatus, haltsum0;

  assign ctrl_wr      = bus.acc && bus.we && (bus.addr == AddrDmControl);
  assign wr_active    = bus.wdata[DmActiveBit];
  assign wr_hartsel   = bus.wdata[HartSelLsb +: $bits(hartsel_t)];
  assign sel_valid    = (hartsel_q < hartsel_t'(NrHarts));
  assign sel_idx      = hartsel_q[HartSelLen-1:0];
  assign wr_sel_valid = (wr_hartsel < hartsel_t'(NrHarts));
  assign wr_sel_idx   = wr_hartsel[HartSelLen-1:0];

  // -------------------------------------------------------------------------
  // dmcontrol
  // -------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dmactive_q  <= 1'b0;
      ndmreset_q  <= 1'b0;
      haltreq_q   <= 1'b0;
      resumereq_q <= 1'b0;
      hartsel_q   <= '0;
    end else if (!dmactive_q) begin
      // inactive module, only dmactive is writable
      ndmreset_q  <= 1'b0;
      haltreq_q   <= 1'b0;
      resumereq_q <= 1'b0;
      hartsel_q   <= '0;
      if (ctrl_wr) begin
        dmactive_q <= wr_active;
      end
    end else if (ctrl_wr) begin
      dmactive_q  <= wr_active;
      ndmreset_q  <= wr_active & bus.wdata[NdmResetBit];
      haltreq_q   <= wr_active & bus.wdata[HaltReqBit];
      resumereq_q <= wr_active & bus.wdata[ResumeReqBit];
      hartsel_q   <= wr_active ? wr_hartsel : '0;
    end else if (resumereq_q && sel_valid && resumeack_i[sel_idx]) begin
      resumereq_q <= 1'b0;
    end
  end

  assign clear_resumeack_o = ctrl_wr && dmactive_q && wr_active && !resumereq_q &&
                             bus.wdata[ResumeReqBit];

  // havereset, set again by ndmreset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      havereset_q <= '1;
    end else if (ndmreset_q) begin
      havereset_q <= '1;
    end else if (ctrl_wr && dmactive_q && bus.wdata[AckHaveResetBit] && wr_sel_valid) begin
      havereset_q[wr_sel_idx] <= 1'b0;
    end
  end

  always_comb begin
    haltreq_o   = '0;
    resumereq_o = '0;
    if (sel_valid) begin
      haltreq_o[sel_idx]   = haltreq_q;
      resumereq_o[sel_idx] = resumereq_q;
    end
  end

  assign ndmreset_o = ndmreset_q;
  assign dmactive_o = dmactive_q;

  // -------------------------------------------------------------------------
  // read words
  // -------------------------------------------------------------------------
  always_comb begin
    dmcontrol                                   = '0;
    dmcontrol[HaltReqBit]                       = haltreq_q;
    dmcontrol[ResumeReqBit]                     = resumereq_q;
    dmcontrol[HartSelLsb +: $bits(hartsel_t)]   = hartsel_q;
    dmcontrol[NdmResetBit]                      = ndmreset_q;
    dmcontrol[DmActiveBit]                      = dmactive_q;

    dmstatus                      = '0;
    dmstatus[3:0]                 = 4'(DbgVersion);
    dmstatus[StatusAuthenticated] = 1'b1;
    if (!sel_valid) begin
      dmstatus[StatusAllNonExistent] = 1'b1;
      dmstatus[StatusAnyNonExistent] = 1'b1;
    end else begin
      dmstatus[StatusAllHaveReset] = havereset_q[sel_idx];
      dmstatus[StatusAnyHaveReset] = havereset_q[sel_idx];
      dmstatus[StatusAllResumeAck] = resumeack_i[sel_idx];
      dmstatus[StatusAnyResumeAck] = resumeack_i[sel_idx];
      dmstatus[StatusAllUnavail]   = unavailable_i[sel_idx];
      dmstatus[StatusAnyUnavail]   = unavailable_i[sel_idx];
      // halted and unavailable are exclusive
      dmstatus[StatusAllHalted]    = halted_i[sel_idx] & ~unavailable_i[sel_idx];
      dmstatus[StatusAnyHalted]    = halted_i[sel_idx] & ~unavailable_i[sel_idx];
      dmstatus[StatusAllRunning]   = ~halted_i[sel_idx] & ~unavailable_i[sel_idx];
      dmstatus[StatusAnyRunning]   = ~halted_i[sel_idx] & ~unavailable_i[sel_idx];
    end

    haltsum0 = '0;
    if (hartsel_q < hartsel_t'(32)) begin
      haltsum0[NrHarts-1:0] = halted_i;
    end

    unique case (bus.addr)
      AddrDmControl: bus.rdata = dmcontrol;
      AddrDmStatus:  bus.rdata = dmstatus;
      AddrHaltSum0:  bus.rdata = haltsum0;
      default:       bus.rdata = '0;
    endcase
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(haltreq_o));
  // requests never leave an inactive module
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !dmactive_o |-> (haltreq_o == '0 && resumereq_o == '0 && !ndmreset_o));

endmodule

`default_nettype wire

/* hw/dm_abstract_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module dm_abstract_regs (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  dm_reg_if.regs                                   bus,
  input  logic                                     dmactive_i,
  input  logic                                     cmdbusy_i,
  input  logic                                     cmderror_valid_i,
  input  dm_pkg::cmderr_e                          cmderror_i,
  input  logic                                     data_valid_i,
  input  dm_pkg::word_t [dm_pkg::DataCount-1:0]    data_i,
  output logic                                     cmd_valid_o,
  output dm_pkg::word_t                            cmd_o,
  output dm_pkg::word_t [dm_pkg::DataCount-1:0]    data_o,
  output dm_pkg::word_t [dm_pkg::ProgBufSize-1:0]  progbuf_o
);
  import dm_pkg::*;

  cmderr_e                    cmderr_d, cmderr_q;
  logic                       cmd_valid_d, cmd_valid_q;
  logic [DataCount-1:0]       auto_data_d, auto_data_q;
  logic [ProgBufSize-1:0]     auto_pb_d, auto_pb_q;
  word_t                      command_d, command_q;
  word_t [DataCount-1:0]      data_d, data_q;
  word_t [ProgBufSize-1:0]    pb_d, pb_q;
  logic                       is_data, is_pb;
  logic [DataIdxLen-1:0]      data_idx;
  logic [ProgBufIdxLen-1:0]   pb_idx;

  // data and progbuf windows are aligned to their size
  assign is_data  = (bus.addr >= AddrData0) &&
                    (bus.addr < AddrData0 + dmi_addr_t'(DataCount));
  assign is_pb    = (bus.addr >= AddrProgBuf0) &&
                    (bus.addr < AddrProgBuf0 + dmi_addr_t'(ProgBufSize));
  assign data_idx = bus.addr[DataIdxLen-1:0];
  assign pb_idx   = bus.addr[ProgBufIdxLen-1:0];

  // -------------------------------------------------------------------------
  // next state
  // -------------------------------------------------------------------------
  always_comb begin
    cmderr_d    = cmderr_q;
    cmd_valid_d = 1'b0;
    auto_data_d = auto_data_q;
    auto_pb_d   = auto_pb_q;
    command_d   = command_q;
    data_d      = data_q;
    pb_d        = pb_q;

    if (bus.acc) begin
      if (is_data) begin
        if (!cmdbusy_i) begin
          if (bus.we) begin
            data_d[data_idx] = bus.wdata;
          end
          cmd_valid_d = auto_data_q[data_idx];
        end
      end else if (is_pb) begin
        if (!cmdbusy_i) begin
          if (bus.we) begin
            pb_d[pb_idx] = bus.wdata;
          end
          cmd_valid_d = auto_pb_q[pb_idx];
        end
      end else if (bus.we) begin
        unique case (bus.addr)
          AddrCommand: begin
            if (!cmdbusy_i) begin
              cmd_valid_d = 1'b1;
              command_d   = bus.wdata;
            end else if (cmderr_q == CmdErrNone) begin
              cmderr_d = CmdErrBusy;
            end
          end
          AddrAbstractAuto: begin
            if (!cmdbusy_i) begin
              auto_data_d = bus.wdata[DataCount-1:0];
              auto_pb_d   = bus.wdata[AutoProgBufLsb +: ProgBufSize];
            end else if (cmderr_q == CmdErrNone) begin
              cmderr_d = CmdErrBusy;
            end
          end
          AddrAbstractCs: begin
            // cmderr is write-one-to-clear
            if (!cmdbusy_i) begin
              cmderr_d = cmderr_e'(cmderr_q & ~bus.wdata[AbsCmdErrLsb +: 3]);
            end else if (cmderr_q == CmdErrNone) begin
              cmderr_d = CmdErrBusy;
            end
          end
          default: ;
        endcase
      end
    end

    // hart-side updates win over the debugger
    if (cmderror_valid_i) begin
      cmderr_d = cmderror_i;
    end
    if (data_valid_i) begin
      data_d = data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmderr_q    <= CmdErrNone;
      cmd_valid_q <= 1'b0;
      auto_data_q <= '0;
      auto_pb_q   <= '0;
    end else if (!dmactive_i) begin
      cmderr_q    <= CmdErrNone;
      cmd_valid_q <= 1'b0;
      auto_data_q <= '0;
      auto_pb_q   <= '0;
    end else begin
      cmderr_q    <= cmderr_d;
      cmd_valid_q <= cmd_valid_d;
      auto_data_q <= auto_data_d;
      auto_pb_q   <= auto_pb_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!dmactive_i) begin
      command_q <= '0;
      data_q    <= '0;
      pb_q      <= '0;
    end else begin
      command_q <= command_d;
      data_q    <= data_d;
      pb_q      <= pb_d;
    end
  end

  // read mux, command reads as zero
  always_comb begin
    bus.rdata = '0;
    if (is_data) begin
      bus.rdata = data_q[data_idx];
    end else if (is_pb) begin
      bus.rdata = pb_q[pb_idx];
    end else if (bus.addr == AddrAbstractCs) begin
      bus.rdata[AbsProgBufSizeLsb +: 5] = 5'(ProgBufSize);
      bus.rdata[AbsBusyBit]             = cmdbusy_i;
      bus.rdata[AbsCmdErrLsb +: 3]      = cmderr_q;
      bus.rdata[AbsDataCountLsb +: 4]   = 4'(DataCount);
    end else if (bus.addr == AddrAbstractAuto) begin
      bus.rdata[AutoProgBufLsb +: ProgBufSize] = auto_pb_q;
      bus.rdata[DataCount-1:0]                 = auto_data_q;
    end
  end

  assign cmd_valid_o = cmd_valid_q;
  assign cmd_o       = command_q;
  assign data_o      = data_q;
  assign progbuf_o   = pb_q;

  // a new command must not be started on a busy hart
  assert property (@(posedge clk_i) disable iff (!rst_ni) cmd_valid_o |-> !cmdbusy_i);

endmodule

`default_nettype wire

/* hw/dm_csrs.sv */
`timescale 1ns/1ps
`default_nettype none

module dm_csrs (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic                                     dmi_req_valid_i,
  output logic                                     dmi_req_ready_o,
  input  dm_pkg::dtm_op_e                          dmi_req_op_i,
  input  dm_pkg::dmi_addr_t                        dmi_req_addr_i,
  input  dm_pkg::word_t                            dmi_req_data_i,
  output logic                                     dmi_resp_valid_o,
  input  logic                                     dmi_resp_ready_i,
  output dm_pkg::word_t                            dmi_resp_data_o,
  input  dm_pkg::hart_vec_t                        halted_i,
  input  dm_pkg::hart_vec_t                        unavailable_i,
  input  dm_pkg::hart_vec_t                        resumeack_i,
  output dm_pkg::hart_vec_t                        haltreq_o,
  output dm_pkg::hart_vec_t                        resumereq_o,
  output logic                                     clear_resumeack_o,
  output logic                                     ndmreset_o,
  output logic                                     dmactive_o,
  input  logic                                     cmdbusy_i,
  input  logic                                     cmderror_valid_i,
  input  dm_pkg::cmderr_e                          cmderror_i,
  input  logic                                     data_valid_i,
  input  dm_pkg::word_t [dm_pkg::DataCount-1:0]    data_i,
  output logic                                     cmd_valid_o,
  output dm_pkg::word_t                            cmd_o,
  output dm_pkg::word_t [dm_pkg::DataCount-1:0]    data_o,
  output dm_pkg::word_t [dm_pkg::ProgBufSize-1:0]  progbuf_o
);

  logic dmactive;

  dm_reg_if hart_bus ();
  dm_reg_if abs_bus ();

  dm_dmi_front u_front (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .dmi_req_valid_i  (dmi_req_valid_i),
    .dmi_req_ready_o  (dmi_req_ready_o),
    .dmi_req_op_i     (dmi_req_op_i),
    .dmi_req_addr_i   (dmi_req_addr_i),
    .dmi_req_data_i   (dmi_req_data_i),
    .dmi_resp_valid_o (dmi_resp_valid_o),
    .dmi_resp_ready_i (dmi_resp_ready_i),
    .dmi_resp_data_o  (dmi_resp_data_o),
    .hart_bus         (hart_bus.front),
    .abs_bus          (abs_bus.front)
  );

  dm_hart_ctrl u_hart_ctrl (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .bus               (hart_bus.regs),
    .halted_i          (halted_i),
    .unavailable_i     (unavailable_i),
    .resumeack_i       (resumeack_i),
    .haltreq_o         (haltreq_o),
    .resumereq_o       (resumereq_o),
    .clear_resumeack_o (clear_resumeack_o),
    .ndmreset_o        (ndmreset_o),
    .dmactive_o        (dmactive)
  );

  dm_abstract_regs u_abstract_regs (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .bus              (abs_bus.regs),
    .dmactive_i       (dmactive),
    .cmdbusy_i        (cmdbusy_i),
    .cmderror_valid_i (cmderror_valid_i),
    .cmderror_i       (cmderror_i),
    .data_valid_i     (data_valid_i),
    .data_i           (data_i),
    .cmd_valid_o      (cmd_valid_o),
    .cmd_o            (cmd_o),
    .data_o           (data_o),
    .progbuf_o        (progbuf_o)
  );

  assign dmactive_o = dmactive;

endmodule

`default_nettype wire

/* verif/tb_dm_csrs.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dm_csrs;
  import dm_pkg::*;

  // well above the length of all directed tests
  localparam int unsigned MaxCycles = 3000;

  logic                         clk_i;
  logic                         rst_ni;
  logic                         dmi_req_valid_i;
  logic                         dmi_req_ready_o;
  dtm_op_e                      dmi_req_op_i;
  dmi_addr_t                    dmi_req_addr_i;
  word_t                        dmi_req_data_i;
  logic                         dmi_resp_valid_o;
  logic                         dmi_resp_ready_i;
  word_t                        dmi_resp_data_o;
  hart_vec_t                    halted_i;
  hart_vec_t                    unavailable_i;
  hart_vec_t                    resumeack_i;
  hart_vec_t                    haltreq_o;
  hart_vec_t                    resumereq_o;
  logic                         clear_resumeack_o;
  logic                         ndmreset_o;
  logic                         dmactive_o;
  logic                         cmdbusy_i;
  logic                         cmderror_valid_i;
  cmderr_e                      cmderror_i;
  logic                         data_valid_i;
  word_t [DataCount-1:0]        data_i;
  logic                         cmd_valid_o;
  word_t                        cmd_o;
  word_t [DataCount-1:0]        data_o;
  word_t [ProgBufSize-1:0]      progbuf_o;

  integer seed;
  int     errors = 0;
  int     checks = 0;
  int     tests_run = 0;
  int     tests_failed = 0;
  int     cycles = 0;
  int     cmd_pulses = 0;
  int     clr_pulses = 0;

  dm_csrs dut (.*);

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  // ------------------------------------------------------------------------
  // pulse counters and run limit
  // ------------------------------------------------------------------------
  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cmd_valid_o) begin
      cmd_pulses = cmd_pulses + 1;
    end
    if (clear_resumeack_o) begin
      clr_pulses = clr_pulses + 1;
    end
    if (cycles >= MaxCycles) begin
      $display("timeout after %0d cycles, a DMI transfer never completed", cycles);
      $display("Result: FAILED");
      $finish;
    end
  end

  task automatic check_word(input string name, input word_t exp, input word_t act);
    checks = checks + 1;
    if (act !== exp) begin
      $display("mismatch at time %0t: %s expected %h actual %h", $time, name, exp, act);
      errors = errors + 1;
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run = tests_run + 1;
    if (errors == errs_before) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, errors - errs_before);
      tests_failed = tests_failed + 1;
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_i);
  endtask

  // dmstatus as the selected hart should report it
  function automatic word_t status_word(input int sel, input logic hr);
    word_t w;
    logic  h;
    logic  u;
    w = 32'h0000_0082;
    if (sel >= NrHarts) begin
      w[15:14] = 2'b11;
    end else begin
      h = halted_i[sel];
      u = unavailable_i[sel];
      w[19:18] = {2{hr}};
      w[17:16] = {2{resumeack_i[sel]}};
      w[13:12] = {2{u}};
      w[11:10] = {2{~h & ~u}};
      w[9:8]   = {2{h & ~u}};
    end
    return w;
  endfunction

  // dmactive is always set in the word
  function automatic word_t ctrl_word(input int hart, input word_t flags);
    return flags | (word_t'(hart) << HartSelLsb) | 32'h1;
  endfunction

  // ------------------------------------------------------------------------
  // DMI access
  // ------------------------------------------------------------------------
  task automatic send_request(input dtm_op_e op, input dmi_addr_t addr, input word_t wdata);
    dmi_req_valid_i <= 1'b1;
    dmi_req_op_i    <= op;
    dmi_req_addr_i  <= addr;
    dmi_req_data_i  <= wdata;
    @(posedge clk_i);
    while (!dmi_req_ready_o) @(posedge clk_i);
    dmi_req_valid_i <= 1'b0;
  endtask

  task automatic take_response(output word_t rdata);
    @(posedge clk_i);
    while (!(dmi_resp_valid_o && dmi_resp_ready_i)) @(posedge clk_i);
    rdata = dmi_resp_data_o;
  endtask

  task automatic dmi_write(input dmi_addr_t addr, input word_t wdata);
    word_t resp;
    send_request(DtmWrite, addr, wdata);
    take_response(resp);
  endtask

  task automatic dmi_read(input dmi_addr_t addr, output word_t rdata);
    send_request(DtmRead, addr, '0);
    take_response(rdata);
  endtask

  // ------------------------------------------------------------------------
  // directed tests
  // ------------------------------------------------------------------------
  task automatic activate_module();
    int    start;
    word_t rd;
    start = errors;
    dmi_read(AddrDmControl, rd);
    check_word("dmcontrol", 32'h0, rd);
    dmi_write(AddrDmControl, 32'h8000_0000);
    check_word("haltreq_o", 32'h0, word_t'(haltreq_o));
    check_word("dmactive_o", 32'h0, word_t'(dmactive_o));
    dmi_write(AddrDmControl, 32'h0000_0001);
    check_word("dmactive_o", 32'h1, word_t'(dmactive_o));
    dmi_read(AddrDmStatus, rd);
    check_word("dmstatus", status_word(0, 1'b1), rd);
    finish_test("activation", start);
  endtask

  task automatic halt_and_resume();
    int    start;
    word_t rd;
    start = errors;
    dmi_write(AddrDmControl, ctrl_word(2, 32'h8000_0000));
    check_word("haltreq_o", 32'h4, word_t'(haltreq_o));
    halted_i <= 4'b0100;
    dmi_read(AddrDmStatus, rd);
    check_word("dmstatus", status_word(2, 1'b1), rd);
    dmi_read(AddrHaltSum0, rd);
    check_word("haltsum0", 32'h4, rd);
    clr_pulses = 0;
    dmi_write(AddrDmControl, ctrl_word(2, 32'h4000_0000));
    wait_cycles(1);
    check_word("clear_resumeack_o pulses", 32'd1, word_t'(clr_pulses));
    check_word("resumereq_o", 32'h4, word_t'(resumereq_o));
    resumeack_i <= 4'b0100;
    wait_cycles(2);
    check_word("resumereq_o", 32'h0, word_t'(resumereq_o));
    dmi_read(AddrDmStatus, rd);
    check_word("dmstatus", status_word(2, 1'b1), rd);
    // hart 5 does not exist, both requests are written
    dmi_write(AddrDmControl, ctrl_word(5, 32'hC000_0000));
    check_word("haltreq_o", 32'h0, word_t'(haltreq_o));
    check_word("resumereq_o", 32'h0, word_t'(resumereq_o));
    dmi_read(AddrDmStatus, rd);
    check_word("dmstatus", status_word(5, 1'b0), rd);
    halted_i    <= '0;
    resumeack_i <= '0;
    finish_test("halt and resume", start);
  endtask

  task automatic track_havereset();
    int    start;
    word_t rd;
    start = errors;
    dmi_write(AddrDmControl, ctrl_word(1, 32'h0));
    dmi_read(AddrDmStatus, rd);
    check_word("dmstatus", status_word(1, 1'b1), rd);
    dmi_write(AddrDmControl, ctrl_word(1, 32'h1000_0000));
    dmi_read(AddrDmStatus, rd);
    check_word("dmstatus", status_word(1, 1'b0), rd);
    dmi_write(AddrDmControl, ctrl_word(0, 32'h0));
    dmi_read(AddrDmStatus, rd);
    check_word("dmstatus", status_word(0, 1'b1), rd);
    dmi_write(AddrDmControl, ctrl_word(1, 32'h2));
    check_word("ndmreset_o", 32'h1, word_t'(ndmreset_o));
    dmi_read(AddrDmStatus, rd);
    check_word("dmstatus", status_word(1, 1'b1), rd);
    dmi_write(AddrDmControl, ctrl_word(1, 32'h0));
    check_word("ndmreset_o", 32'h0, word_t'(ndmreset_o));
    finish_test("reset tracking", start);
  endtask

  task automatic run_abstract_cmd();
    int    start;
    word_t rd;
    word_t cmd;
    start = errors;
    dmi_read(AddrAbstractCs, rd);
    check_word("abstractcs", 32'h0800_0002, rd);
    cmd        = $random(seed);
    cmd_pulses = 0;
    dmi_write(AddrCommand, cmd);
    wait_cycles(1);
    check_word("cmd_valid_o pulses", 32'd1, word_t'(cmd_pulses));
    check_word("cmd_o", cmd, cmd_o);
    // command while the hart is busy
    cmdbusy_i <= 1'b1;
    dmi_write(AddrCommand, ~cmd);
    dmi_read(AddrAbstractCs, rd);
    check_word("abstractcs", 32'h0800_1102, rd);
    check_word("cmd_valid_o pulses", 32'd1, word_t'(cmd_pulses));
    check_word("cmd_o", cmd, cmd_o);
    cmdbusy_i <= 1'b0;
    dmi_write(AddrAbstractCs, 32'h0000_0700);
    dmi_read(AddrAbstractCs, rd);
    check_word("abstractcs", 32'h0800_0002, rd);
    cmderror_valid_i <= 1'b1;
    cmderror_i       <= CmdErrException;
    @(posedge clk_i);
    cmderror_valid_i <= 1'b0;
    dmi_read(AddrAbstractCs, rd);
    check_word("abstractcs", 32'h0800_0302, rd);
    dmi_write(AddrAbstractCs, 32'h0000_0700);
    finish_test("abstract command", start);
  endtask

  task automatic fill_data_progbuf();
    int    start;
    int    i;
    word_t rd;
    word_t dw [DataCount];
    word_t pw [ProgBufSize];
    start = errors;
    for (i = 0; i < DataCount; i++) begin
      dw[i] = $random(seed);
      dmi_write(AddrData0 + dmi_addr_t'(i), dw[i]);
    end
    for (i = 0; i < ProgBufSize; i++) begin
      pw[i] = $random(seed);
      dmi_write(AddrProgBuf0 + dmi_addr_t'(i), pw[i]);
    end
    for (i = 0; i < DataCount; i++) begin
      dmi_read(AddrData0 + dmi_addr_t'(i), rd);
      check_word($sformatf("data%0d", i), dw[i], rd);
      check_word($sformatf("data_o[%0d]", i), dw[i], data_o[i]);
    end
    for (i = 0; i < ProgBufSize; i++) begin
      dmi_read(AddrProgBuf0 + dmi_addr_t'(i), rd);
      check_word($sformatf("progbuf%0d", i), pw[i], rd);
      check_word($sformatf("progbuf_o[%0d]", i), pw[i], progbuf_o[i]);
    end
    // hart side loads both data words
    dw[0] = $random(seed);
    dw[1] = $random(seed);
    data_valid_i <= 1'b1;
    data_i       <= {dw[1], dw[0]};
    @(posedge clk_i);
    data_valid_i <= 1'b0;
    for (i = 0; i < DataCount; i++) begin
      dmi_read(AddrData0 + dmi_addr_t'(i), rd);
      check_word($sformatf("data%0d", i), dw[i], rd);
    end
    dmi_write(AddrAbstractAuto, 32'h1);
    cmd_pulses = 0;
    dmi_read(AddrData0, rd);
    wait_cycles(1);
    check_word("cmd_valid_o pulses", 32'd1, word_t'(cmd_pulses));
    dmi_write(AddrAbstractAuto, 32'h0);
    finish_test("data and progbuf", start);
  endtask

  task automatic hold_back_responses();
    int    start;
    word_t a;
    word_t b;
    word_t rd0;
    word_t rd1;
    start = errors;
    a     = $random(seed);
    b     = $random(seed);
    dmi_write(AddrData0, a);
    dmi_write(AddrData0 + 7'd1, b);
    dmi_resp_ready_i <= 1'b0;
    send_request(DtmRead, AddrData0, '0);
    send_request(DtmRead, AddrData0 + 7'd1, '0);
    @(posedge clk_i);
    check_word("dmi_req_ready_o", 32'h0, word_t'(dmi_req_ready_o));
    wait_cycles(2);
    check_word("dmi_req_ready_o", 32'h0, word_t'(dmi_req_ready_o));
    check_word("dmi_resp_valid_o", 32'h1, word_t'(dmi_resp_valid_o));
    dmi_resp_ready_i <= 1'b1;
    take_response(rd0);
    take_response(rd1);
    check_word("first response", a, rd0);
    check_word("second response", b, rd1);
    finish_test("back-pressure", start);
  endtask

  initial begin
    seed             = 32'h9353_15b9;
    rst_ni           = 1'b0;
    dmi_req_valid_i  = 1'b0;
    dmi_req_op_i     = DtmNop;
    dmi_req_addr_i   = '0;
    dmi_req_data_i   = '0;
    dmi_resp_ready_i = 1'b1;
    halted_i         = '0;
    unavailable_i    = '0;
    resumeack_i      = '0;
    cmdbusy_i        = 1'b0;
    cmderror_valid_i = 1'b0;
    cmderror_i       = CmdErrNone;
    data_valid_i     = 1'b0;
    data_i           = '0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    activate_module();
    halt_and_resume();
    track_havereset();
    run_abstract_cmd();
    fill_data_progbuf();
    hold_back_responses();
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
hw/dm_pkg.sv
hw/dm_reg_if.sv
hw/dm_resp_fifo.sv
hw/dm_dmi_front.sv
hw/dm_hart_ctrl.sv
hw/dm_abstract_regs.sv
hw/dm_csrs.sv
verif/tb_dm_csrs.sv
